/* Makefile */
# Verilator simulation of the PHY management testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_phy_mgmt -f project.f

run: compile
	./obj_dir/Vtb_phy_mgmt +verilator+error+limit+1000 2>&1 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* mdio_cmd_if.sv */
// ####################
// one register write command, valid/ready handshake
// fields must hold while valid is high
// ####################
`timescale 1ns/1ps

interface mdio_cmd_if;

    import phy_mgmt_pkg::*;

    reg_addr_t reg_addr;
    reg_data_t data;
    logic      valid;
    logic      ready;

    modport sequencer (
        output reg_addr,
        output data,
        output valid,
        input  ready
    );

    modport serializer (
        input  reg_addr,
        input  data,
        input  valid,
        output ready
    );

endinterface

/* mdio_write_master.sv */
// ####################
// Clause 22 write serializer, MDC = clk / (2 * MDC_HALF_CYCLES)
// output only, no reads and no turnaround release
// ####################
`timescale 1ns/1ps

module mdio_write_master (
    input  logic           clk_125mhz_int,
    input  logic           rst_125mhz_int,
    mdio_cmd_if.serializer cmd,
    output logic           mdc_o,
    output logic           mdio_o,
    output logic           mdio_oe_o
);

    import phy_mgmt_pkg::*;

    logic                 busy;
    logic                 xfer;
    logic [MDC_CNT_W-1:0] pre_cnt;
    logic                 mdc_phase;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 half_end;
    mdio_frame_t          frame_next;
    mdio_frame_t          shift_reg;

    assign cmd.ready = !busy;
    assign xfer      = cmd.valid && !busy;
    assign half_end  = (pre_cnt == MDC_CNT_W'(MDC_HALF_CYCLES - 1));

    // preamble, start, opcode, phy, reg, turnaround, data
    assign frame_next = {
        {PREAMBLE_BITS{1'b1}},
        MDIO_START,
        MDIO_OP_WRITE,
        PHY_ADDR,
        cmd.reg_addr,
        MDIO_TA_WRITE,
        cmd.data
    };

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy      <= 1'b0;
            pre_cnt   <= '0;
            mdc_phase <= 1'b0;
            bit_cnt   <= '0;
            mdc_o     <= 1'b0;
            mdio_o    <= 1'b1;
            mdio_oe_o <= 1'b0;
        end else if (!busy) begin
            if (xfer) begin
                // first bit goes out with MDC low
                busy      <= 1'b1;
                pre_cnt   <= '0;
                mdc_phase <= 1'b0;
                bit_cnt   <= '0;
                mdio_o    <= frame_next[FRAME_BITS-1];
                mdio_oe_o <= 1'b1;
            end
        end else if (half_end) begin
            pre_cnt   <= '0;
            mdc_phase <= ~mdc_phase;
            // MDC only shows during the frame, the idle bit stays low
            mdc_o     <= ~mdc_phase && (bit_cnt < BIT_CNT_W'(FRAME_BITS));
            if (mdc_phase) begin
                // falling edge ends a bit period
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == BIT_CNT_W'(FRAME_BITS)) begin
                    busy <= 1'b0;
                end else if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
                    mdio_o    <= 1'b1;
                    mdio_oe_o <= 1'b0;
                end else begin
                    mdio_o <= shift_reg[FRAME_BITS-2];
                end
            end
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // frame payload
    always_ff @(posedge clk_125mhz_int) begin
        if (xfer) begin
            shift_reg <= frame_next;
        end else if (busy && half_end && mdc_phase) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

/* phy_init_seq.sv */
// ####################
// power-up delay, then the fixed twelve PHY writes in table order
// one command in flight, done stays high until reset
// ####################
`timescale 1ns/1ps

module phy_init_seq #(
    parameter int unsigned INIT_DELAY_CYCLES = phy_mgmt_pkg::INIT_DELAY_DEFAULT
) (
    input  logic          clk_125mhz_int,
    input  logic          rst_125mhz_int,
    mdio_cmd_if.sequencer cmd,
    output logic          init_done_o
);

    import phy_mgmt_pkg::*;

    // wide enough for the load value, also when the delay is zero
    localparam int DELAY_W = $clog2(INIT_DELAY_CYCLES + 2);

    init_state_t        state;
    logic [DELAY_W-1:0] delay_cnt;
    init_idx_t          idx;
    logic               xfer;
    logic               last_entry;

    // command fields come straight from the table, stable while idx holds
    assign cmd.valid    = (state == INIT_ISSUE) || (state == INIT_WAIT);
    assign cmd.reg_addr = init_reg_table[idx];
    assign cmd.data     = init_data_table[idx];

    assign xfer        = cmd.valid && cmd.ready;
    assign last_entry  = (idx == init_idx_t'(INIT_WRITES - 1));
    assign init_done_o = (state == INIT_DONE);

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state     <= INIT_DELAY;
            delay_cnt <= DELAY_W'(INIT_DELAY_CYCLES);
            idx       <= '0;
        end else begin
            case (state)
                INIT_DELAY: begin
                    // valid comes up after exactly INIT_DELAY_CYCLES clocks
                    if (delay_cnt <= DELAY_W'(1)) begin
                        state <= INIT_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                INIT_ISSUE, INIT_WAIT: begin
                    if (xfer) begin
                        if (last_entry) begin
                            state <= INIT_DONE;
                        end else begin
                            // next entry is presented right away
                            idx   <= idx + 1'b1;
                            state <= INIT_ISSUE;
                        end
                    end else begin
                        // serializer busy with the previous frame
                        state <= INIT_WAIT;
                    end
                end
                INIT_DONE: begin
                    state <= INIT_DONE;
                end
                default: begin
                    state <= INIT_DELAY;
                end
            endcase
        end
    end

endmodule

/* phy_mgmt_chk.sv */
// ####################
// MDIO pin rules and a sticky done flag, bound into phy_mgmt_top
// ####################
`timescale 1ns/1ps

module phy_mgmt_chk (
    input logic clk_i,
    input logic rst_i,
    input logic mdc_i,
    input logic mdio_i,
    input logic mdio_oe_i,
    input logic done_i
);

    int fail_cnt = 0;

    // no MDC pulses while the pin driver is off
    mdc_idle_low: assert property (@(posedge clk_i) disable iff (rst_i) !mdio_oe_i |-> !mdc_i)
        else begin
            $error("MDC high while the MDIO output enable is low");
            fail_cnt++;
        end

    mdio_setup_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(mdc_i) |-> $stable(mdio_i))
        else begin
            $error("MDIO changed in the cycle where MDC rose");
            fail_cnt++;
        end

    done_sticky: assert property (@(posedge clk_i) $fell(done_i) |-> rst_i)
        else begin
            $error("init done fell without a reset");
            fail_cnt++;
        end

endmodule

bind phy_mgmt_top phy_mgmt_chk u_chk (
    .clk_i    (clk_125mhz_int),
    .rst_i    (rst_125mhz_int),
    .mdc_i    (phy_mdc_o),
    .mdio_i   (phy_mdio_o),
    .mdio_oe_i(phy_mdio_oe_o),
    .done_i   (init_done_o)
);

/* phy_mgmt_pkg.sv */
// ####################
// constants, types and the PHY init write table for the MDIO path
// write only, Clause 22 frames, one fixed PHY address
// ####################
package phy_mgmt_pkg;

    typedef logic [4:0]  phy_addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [63:0] mdio_frame_t;
    typedef logic [3:0]  init_idx_t;

    typedef enum logic [1:0] {
        INIT_DELAY,
        INIT_ISSUE,
        INIT_WAIT,
        INIT_DONE
    } init_state_t;

    localparam phy_addr_t PHY_ADDR = 5'd3;
    localparam reg_addr_t REG_REGCR = 5'h0D;
    localparam reg_addr_t REG_ADDAR = 5'h0E;

    // clocks per MDC half period, 125 MHz / 8 gives a 15.6 MHz MDC
    localparam int MDC_HALF_CYCLES = 4;
    localparam int PREAMBLE_BITS = 32;
    localparam int FRAME_BITS = 64;
    localparam int INIT_WRITES = 12;
    localparam int unsigned INIT_DELAY_DEFAULT = 20'hfffff;

    localparam int MDC_CNT_W = $clog2(MDC_HALF_CYCLES);
    // frame bits plus one idle bit period
    localparam int BIT_CNT_W = $clog2(FRAME_BITS + 2);

    // fixed frame fields of a Clause 22 write
    localparam logic [1:0] MDIO_START = 2'b01;
    localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
    localparam logic [1:0] MDIO_TA_WRITE = 2'b10;

    // REGCR function codes for MMD device 0x1F
    localparam reg_data_t REGCR_FN_ADDR = 16'h001F;
    localparam reg_data_t REGCR_FN_DATA = 16'h401F;

    // REGCR, ADDAR pairs: address phase then data phase per extended register
    localparam reg_addr_t init_reg_table [INIT_WRITES] = '{
        REG_REGCR, REG_ADDAR, REG_REGCR, REG_ADDAR,
        REG_REGCR, REG_ADDAR, REG_REGCR, REG_ADDAR,
        REG_REGCR, REG_ADDAR, REG_REGCR, REG_ADDAR
    };

    localparam reg_data_t init_data_table [INIT_WRITES] = '{
        // CFG4, SGMII autoneg timer
        REGCR_FN_ADDR, 16'h0031, REGCR_FN_DATA, 16'h0070,
        // SGMIICTL1, SGMII clock output enable
        REGCR_FN_ADDR, 16'h00D3, REGCR_FN_DATA, 16'h4000,
        // 10M_SGMII_CFG, 10 Mb/s over SGMII
        REGCR_FN_ADDR, 16'h016F, REGCR_FN_DATA, 16'h0015
    };

endpackage

/* phy_mgmt_top.sv */
// ####################
// PHY management top, clock and reset arrive clean
// MDIO pad tristate lives outside, use phy_mdio_oe_o
// ####################
`timescale 1ns/1ps

module phy_mgmt_top #(
    parameter int unsigned INIT_DELAY_CYCLES = phy_mgmt_pkg::INIT_DELAY_DEFAULT
) (
    input  logic clk_125mhz_int,
    input  logic rst_125mhz_int,
    output logic phy_mdc_o,
    output logic phy_mdio_o,
    output logic phy_mdio_oe_o,
    output logic init_done_o
);

    mdio_cmd_if u_cmd ();

    // write sequence for the SGMII setup registers
    phy_init_seq #(
        .INIT_DELAY_CYCLES(INIT_DELAY_CYCLES)
    ) u_seq (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd           (u_cmd.sequencer),
        .init_done_o   (init_done_o)
    );

    mdio_write_master u_mdio (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd           (u_cmd.serializer),
        .mdc_o         (phy_mdc_o),
        .mdio_o        (phy_mdio_o),
        .mdio_oe_o     (phy_mdio_oe_o)
    );

endmodule

/* project.f */
phy_mgmt_pkg.sv
mdio_cmd_if.sv
phy_init_seq.sv
mdio_write_master.sv
phy_mgmt_top.sv
phy_mgmt_chk.sv
tb_mdio_monitor.sv
tb_phy_mgmt.sv

/* tb_mdio_monitor.sv */
// ####################
// decodes write frames from the pins on MDC rising edges
// expects the twelve init writes, restarts at entry 0 on reset
// ####################
`timescale 1ns/1ps

module tb_mdio_monitor (
    input  logic clk_i,
    input  logic rst_i,
    input  logic mdc_i,
    input  logic mdio_i,
    input  logic mdio_oe_i,
    output int   frame_cnt_o,
    output int   err_cnt_o,
    output int   drop_cnt_o
);

    logic [63:0] rx_frame;
    int          rx_bits;
    logic        mdc_q;

    // REGCR/ADDAR indirect writes, three extended registers
    function automatic logic [63:0] exp_frame(input int idx);
        logic [4:0]  reg_num;
        logic [15:0] data;
        logic [15:0] target_reg;
        logic [15:0] target_val;
        case (idx / 4)
            0: begin
                target_reg = 16'h0031;
                target_val = 16'h0070;
            end
            1: begin
                target_reg = 16'h00D3;
                target_val = 16'h4000;
            end
            default: begin
                target_reg = 16'h016F;
                target_val = 16'h0015;
            end
        endcase
        reg_num = (idx % 2 == 0) ? 5'h0D : 5'h0E;
        case (idx % 4)
            0: data = 16'h001F;
            1: data = target_reg;
            2: data = 16'h401F;
            default: data = target_val;
        endcase
        return {32'hFFFF_FFFF, 2'b01, 2'b01, 5'd3, reg_num, 2'b10, data};
    endfunction

    task automatic check_frame(input int idx, input logic [63:0] rx);
        logic [63:0] exp;
        int          errs;
        errs = 0;
        if (rx[63:32] !== 32'hFFFF_FFFF) begin
            $display("FAIL frame %0d preamble expected 0xffffffff got 0x%h", idx, rx[63:32]);
            errs++;
        end
        if (rx[31:28] !== 4'b0101) begin
            $display("FAIL frame %0d start and opcode expected 0x5 got 0x%h", idx, rx[31:28]);
            errs++;
        end
        if (rx[27:23] !== 5'd3) begin
            $display("FAIL frame %0d phy address expected 0x03 got 0x%h", idx, rx[27:23]);
            errs++;
        end
        if (rx[17:16] !== 2'b10) begin
            $display("FAIL frame %0d turnaround expected 0x2 got 0x%h", idx, rx[17:16]);
            errs++;
        end
        if (idx >= 12) begin
            $display("frame %0d arrived after the last table write", idx);
            errs++;
        end else begin
            exp = exp_frame(idx);
            if (rx !== exp) begin
                $display("FAIL frame %0d phy_mdio_o expected 0x%h got 0x%h", idx, exp, rx);
                errs++;
            end
        end
        if (errs == 0) begin
            $display("frame %0d reg 0x%h data 0x%h matches", idx, rx[22:18], rx[15:0]);
        end
        err_cnt_o += errs;
    endtask

    initial begin
        frame_cnt_o = 0;
        err_cnt_o = 0;
        drop_cnt_o = 0;
        rx_bits = 0;
        mdc_q = 1'b0;
    end

    // mid-cycle sampling, away from the DUT clock edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            if (rx_bits != 0) begin
                $display("frame %0d dropped by reset after %0d bits", frame_cnt_o, rx_bits);
                drop_cnt_o++;
            end
            rx_bits = 0;
            frame_cnt_o = 0;
        end else if (mdio_oe_i && mdc_i && !mdc_q) begin
            rx_frame = {rx_frame[62:0], mdio_i};
            rx_bits++;
            if (rx_bits == 64) begin
                check_frame(frame_cnt_o, rx_frame);
                rx_bits = 0;
                frame_cnt_o++;
            end
        end else if (!mdio_oe_i && rx_bits != 0) begin
            $display("frame %0d ended after only %0d of 64 bits", frame_cnt_o, rx_bits);
            err_cnt_o++;
            rx_bits = 0;
        end
        mdc_q = mdc_i;
    end

endmodule

/* tb_phy_mgmt.sv */
// ####################
// testbench for phy_mgmt_top with the power-up delay cut to 100 cycles
// a second reset lands inside the fifth frame of the first sequence
// ####################
`timescale 1ns/1ps

module tb_phy_mgmt;

    localparam int DELAY_CYCLES = 100;
    localparam int RST_CYCLES = 16;
    // two full sequences at about 600 clocks per write
    localparam int TIMEOUT_CYCLES = RST_CYCLES + 2 * (DELAY_CYCLES + 12 * 600) + 200;

    logic clk_125mhz_int;
    logic rst_125mhz_int;
    logic phy_mdc;
    logic phy_mdio;
    logic phy_mdio_oe;
    logic init_done;

    int frame_cnt;
    int mon_err_cnt;
    int drop_cnt;
    int cycle_cnt = 0;
    int quiet_err_cnt = 0;
    int idle_err_cnt = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit done_ok;

    phy_mgmt_top #(
        .INIT_DELAY_CYCLES(DELAY_CYCLES)
    ) u_dut (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .phy_mdc_o     (phy_mdc),
        .phy_mdio_o    (phy_mdio),
        .phy_mdio_oe_o (phy_mdio_oe),
        .init_done_o   (init_done)
    );

    tb_mdio_monitor u_mon (
        .clk_i      (clk_125mhz_int),
        .rst_i      (rst_125mhz_int),
        .mdc_i      (phy_mdc),
        .mdio_i     (phy_mdio),
        .mdio_oe_i  (phy_mdio_oe),
        .frame_cnt_o(frame_cnt),
        .err_cnt_o  (mon_err_cnt),
        .drop_cnt_o (drop_cnt)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    always @(posedge clk_125mhz_int) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the init sequence never completed", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge clk_125mhz_int);
        #1;
        rst_125mhz_int = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_125mhz_int);
        #1;
        rst_125mhz_int = 1'b0;
    endtask

    // no MDC, no OE and no done for n clocks
    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk_125mhz_int);
            if (phy_mdc !== 1'b0 || phy_mdio_oe !== 1'b0 || init_done !== 1'b0) begin
                $display("FAIL phy_mdc_o 0x%h phy_mdio_oe_o 0x%h init_done_o 0x%h, expected 0x0",
                    phy_mdc, phy_mdio_oe, init_done);
                quiet_err_cnt++;
            end
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        rst_125mhz_int = 1'b1;
        fork
            apply_reset();
            check_quiet(RST_CYCLES);
        join
        check_quiet(DELAY_CYCLES);
        report_test("reset and power-up delay quiet", quiet_err_cnt == 0);

        // reset again partway into the fifth frame
        wait (frame_cnt == 4);
        wait (phy_mdio_oe == 1'b0);
        wait (phy_mdio_oe == 1'b1);
        repeat (200) @(posedge clk_125mhz_int);
        apply_reset();
        check_quiet(DELAY_CYCLES);
        report_test("mid-frame reset drops the partial frame",
            drop_cnt == 1 && quiet_err_cnt == 0 && mon_err_cnt == 0);

        wait (frame_cnt == 1);
        report_test("sequence restarts at entry 0", mon_err_cnt == 0);

        // done comes up as the last frame starts
        wait (init_done == 1'b1);
        done_ok = (frame_cnt == 11);
        wait (frame_cnt == 12);
        report_test("twelve frames in order with done", done_ok && mon_err_cnt == 0);

        wait (phy_mdio_oe == 1'b0);
        repeat (2000) begin
            @(negedge clk_125mhz_int);
            if (phy_mdc !== 1'b0 || init_done !== 1'b1) begin
                $display("FAIL phy_mdc_o 0x%h init_done_o 0x%h when idle, expected 0x0 0x1",
                    phy_mdc, init_done);
                idle_err_cnt++;
            end
        end
        report_test("bus idle after done", idle_err_cnt == 0 && frame_cnt == 12);

        $display("tests passed %0d failed %0d, monitor errors %0d, assertion failures %0d",
            tests_passed, tests_failed, mon_err_cnt, u_dut.u_chk.fail_cnt);
        if (tests_failed == 0 && mon_err_cnt == 0 && u_dut.u_chk.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
